//--- qsic_defines.svh
////////////////////
// widths, window base, table size, offset granule and settle depth
// for the qbus slave and load table
////////////////////
`ifndef QSIC_DEFINES_SVH
`define QSIC_DEFINES_SVH

// bus widths
`define QSIC_DAL_W          22      // data/address lines
`define QSIC_DATA_W         16      // bus data word
`define QSIC_IOADDR_W       13      // decoded i/o page address

// load table window, top 16 words of the i/o page, only with bs7
`define QSIC_LT_BASE        13'o17740
`define QSIC_LT_ENTRIES     8       // pack entries, 3-bit drive select

// translation
`define QSIC_LBA_W          32      // storage block address
`define QSIC_DRV_LBA_W      13      // drive block number
`define QSIC_OFFSET_SHIFT   13      // offset counted in 8192-block units

// extra din stages before reply, lets the cable settle
`define QSIC_SETTLE         1

`endif

//--- qsic_pkg.sv
////////////////////
// shared packed structs for bus strobes, dal controls,
// load table entries and translation request/result
////////////////////
`include "qsic_defines.svh"
`default_nettype none

package qsic_pkg;

   // synchronized receive strobes
   typedef struct packed {
      logic sync;
      logic din;
      logic dout;
   } bus_rx_t;

   // transceiver controls
   typedef struct packed {
      logic be;   // drive bdal
      logic st;   // latch output data
      logic tx;   // level shifters toward the bus
   } dal_ctl_t;

   // one disk pack entry
   typedef struct packed {
      logic                    en;      // pack loaded
      logic [1:0]              dev;     // storage device
      logic [`QSIC_DATA_W-1:0] offset;  // in granules
   } lt_entry_t;

   // drive side request
   typedef struct packed {
      logic [$clog2(`QSIC_LT_ENTRIES)-1:0] sel;  // drive select
      logic [`QSIC_DRV_LBA_W-1:0]          blk;  // block on that drive
   } xlate_cmd_t;

   // translation result
   typedef struct packed {
      logic [`QSIC_LBA_W-1:0] lba;  // block on the storage device
      logic [1:0]             dev;
      logic                   ok;   // pack loaded and device ready
   } xlate_rsp_t;

endpackage

`default_nettype wire

//--- sync_chain.sv
////////////////////
// two-flop synchronizer, payload type as parameter
////////////////////
`default_nettype none

module sync_chain #(
   parameter type T = logic
) (
   input  wire logic clk20,
   input  wire logic rst_n,
   input  wire T     d,      // async input
   output T          q       // in clk20
);

   T meta;   // first stage, may go metastable

   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         meta <= '0;
         q    <= '0;
      end else begin
         meta <= d;
         q    <= meta;
      end
   end

endmodule

`default_nettype wire

//--- qbus_slave_ctl.sv
////////////////////
// qbus slave control, address capture, window decode
// and the dati/dato reply sequencer
////////////////////
`include "qsic_defines.svh"
`default_nettype none

module qbus_slave_ctl
   import qsic_pkg::*;
(
   input  wire logic                    clk20,
   input  wire logic                    rst_n,
   input  wire bus_rx_t                 rx,         // already synchronized
   input  wire logic [`QSIC_DAL_W-1:0]  dal_in,
   input  wire logic                    bs7,
   input  wire logic                    wtbt,
   output logic                         trply,
   output dal_ctl_t                     dal_ctl,
   output logic [`QSIC_DAL_W-1:0]       dal_out,
   output logic [3:0]                   reg_idx,    // word within the window
   output logic                         reg_wr,
   output logic [`QSIC_DATA_W-1:0]      reg_wdata,
   input  wire logic [`QSIC_DATA_W-1:0] reg_rdata
);

   localparam int DAL_W  = `QSIC_DAL_W;
   localparam int SETTLE = `QSIC_SETTLE;
   localparam logic [`QSIC_IOADDR_W-1:0] LT_BASE = `QSIC_LT_BASE;

   logic                      sync_d;     // last rx.sync
   logic                      dout_d;     // last rx.dout
   logic [SETTLE-1:0]         din_hist;   // din delayed for settling
   logic [`QSIC_IOADDR_W-1:1] addr_q;     // word address, byte bit dropped
   logic                      bs7_q;
   logic                      wr_q;       // wtbt at address time, a write cycle
   logic                      sync_rise;
   logic                      dout_rise;
   logic                      in_cyc;
   logic                      win_hit;
   logic                      match;
   logic                      rd_go;
   logic                      rd_settled;

   assign sync_rise = rx.sync & ~sync_d;
   assign dout_rise = rx.dout & ~dout_d;
   assign in_cyc    = rx.sync & sync_d;   // addr_q valid from the clock after the rise

   // 16 words = 32 bytes, so bits 12..5 pick the window
   assign win_hit = addr_q[`QSIC_IOADDR_W-1:5] == LT_BASE[`QSIC_IOADDR_W-1:5];
   assign match   = in_cyc & bs7_q & win_hit;

   assign rd_go      = match & rx.din;                 // start tx
   assign rd_settled = rd_go & din_hist[SETTLE-1];     // din held long enough
   assign reg_idx    = addr_q[4:1];

   // edge history and cycle flags
   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         sync_d   <= 1'b0;
         dout_d   <= 1'b0;
         din_hist <= '0;
         bs7_q    <= 1'b0;
         wr_q     <= 1'b0;
      end else begin
         sync_d   <= rx.sync;
         dout_d   <= rx.dout;
         din_hist <= SETTLE'({din_hist, rx.din});   // shift in, oldest falls off
         if (sync_rise) begin
            bs7_q <= bs7;
            wr_q  <= wtbt;
         end
      end
   end

   // address held steady by the master around sync
   always_ff @(posedge clk20) begin
      if (sync_rise) begin
         addr_q <= dal_in[`QSIC_IOADDR_W-1:1];
      end
   end

   // reply sequencer
   // tx first, be/st/trply follow once din has settled
   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         trply   <= 1'b0;
         dal_ctl <= '0;
         reg_wr  <= 1'b0;
      end else begin
         dal_ctl.tx <= rd_go;
         dal_ctl.be <= rd_settled;
         dal_ctl.st <= rd_settled;
         trply      <= rd_settled | (match & rx.dout);   // dato replies as long as dout
         reg_wr     <= match & dout_rise & wr_q;         // one strobe per dato
      end
   end

   // data paths
   always_ff @(posedge clk20) begin
      reg_wdata <= dal_in[`QSIC_DATA_W-1:0];            // lines up with reg_wr
      dal_out   <= rd_go ? DAL_W'(reg_rdata) : '0;       // zero-extended word
   end

endmodule

`default_nettype wire

//--- load_table.sv
////////////////////
// disk pack load table, bus access and reset contents
// plus the loaded vector and one lookup port
////////////////////
`include "qsic_defines.svh"
`default_nettype none

module load_table
   import qsic_pkg::*;
(
   input  wire logic                                 clk20,
   input  wire logic                                 rst_n,
   input  wire logic [3:0]                           reg_idx,
   input  wire logic                                 reg_wr,
   input  wire logic [`QSIC_DATA_W-1:0]              reg_wdata,
   output logic [`QSIC_DATA_W-1:0]                   reg_rdata,
   input  wire logic [3:0]                           dev_ready,   // one per device
   input  wire logic [$clog2(`QSIC_LT_ENTRIES)-1:0]  lt_sel,
   output lt_entry_t                                 lt_entry,
   output logic [`QSIC_LT_ENTRIES-1:0]               loaded
);

   localparam int ENTRIES = `QSIC_LT_ENTRIES;
   localparam int DATA_W  = `QSIC_DATA_W;

   // power-up packs, offsets in granules
   localparam lt_entry_t RST_TBL [ENTRIES] = '{
      '{en: 1'b1, dev: 2'd0, offset: 16'h0010},
      '{en: 1'b1, dev: 2'd2, offset: 16'h0000},   // ramdisk
      '{en: 1'b1, dev: 2'd0, offset: 16'h0012},
      '{en: 1'b1, dev: 2'd0, offset: 16'h0013},
      '{en: 1'b1, dev: 2'd0, offset: 16'h0014},
      '{en: 1'b0, dev: 2'd0, offset: 16'h0015},
      '{en: 1'b0, dev: 2'd0, offset: 16'h0016},
      '{en: 1'b1, dev: 2'd2, offset: 16'h0001}    // ramdisk
   };

   lt_entry_t                      tbl [ENTRIES];
   logic [$clog2(ENTRIES)-1:0]     widx;   // entry for the bus word
   lt_entry_t                      rent;

   // even word = control, odd word = offset
   assign widx = reg_idx[3:1];
   assign rent = tbl[widx];

   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         tbl <= RST_TBL;
      end else if (reg_wr) begin
         if (reg_idx[0]) begin
            tbl[widx].offset <= reg_wdata;
         end else begin
            tbl[widx].en  <= reg_wdata[DATA_W-1];   // bit 15
            tbl[widx].dev <= reg_wdata[1:0];
         end
      end
   end

   // control word reads back only bit 15 and 1..0
   always_comb begin
      if (reg_idx[0]) begin
         reg_rdata = rent.offset;
      end else begin
         reg_rdata = {rent.en, {(DATA_W-3){1'b0}}, rent.dev};
      end
   end

   // pack counts as loaded when enabled and its device is up
   always_comb begin
      for (int i = 0; i < ENTRIES; i++) begin
         loaded[i] = tbl[i].en & dev_ready[tbl[i].dev];
      end
   end

   assign lt_entry = tbl[lt_sel];   // lookup for the translator

endmodule

`default_nettype wire

//--- block_xlate.sv
////////////////////
// four-phase translation responder
// drive select + block to storage block address
////////////////////
`include "qsic_defines.svh"
`default_nettype none

module block_xlate
   import qsic_pkg::*;
(
   input  wire logic                                 clk20,
   input  wire logic                                 rst_n,
   input  wire logic                                 xlate_req,
   input  wire xlate_cmd_t                           xlate_cmd,
   output logic                                      xlate_ack,
   output xlate_rsp_t                                xlate_rsp,
   output logic [$clog2(`QSIC_LT_ENTRIES)-1:0]       lt_sel,
   input  wire lt_entry_t                            lt_entry,
   input  wire logic [`QSIC_LT_ENTRIES-1:0]          loaded
);

   localparam int LBA_W = `QSIC_LBA_W;

   logic             sel_ok;   // lookup matches the current command
   logic             take;     // latch result, raise ack
   logic [LBA_W-1:0] lba_n;

   // ack comes the clock after req when the command was already up a clock earlier,
   // otherwise one clock later while lt_sel catches up
   assign sel_ok = (lt_sel == xlate_cmd.sel);
   assign take   = xlate_req & ~xlate_ack & sel_ok;

   assign lba_n = LBA_W'(xlate_cmd.blk)
                + (LBA_W'(lt_entry.offset) << `QSIC_OFFSET_SHIFT);

   // select register feeds the table lookup
   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         lt_sel <= '0;
      end else begin
         lt_sel <= xlate_cmd.sel;
      end
   end

   // handshake
   always_ff @(posedge clk20) begin
      if (!rst_n) begin
         xlate_ack <= 1'b0;
      end else if (take) begin
         xlate_ack <= 1'b1;
      end else if (!xlate_req) begin
         xlate_ack <= 1'b0;   // phase 4, req gone
      end
   end

   // result held as long as ack
   always_ff @(posedge clk20) begin
      if (take) begin
         xlate_rsp.lba <= lba_n;
         xlate_rsp.dev <= lt_entry.dev;
         xlate_rsp.ok  <= loaded[lt_sel];   // enable already folded in
      end
   end

endmodule

`default_nettype wire

//--- qsic_top.sv
////////////////////
// qbus slave top, synchronizers, slave control,
// load table and block translator
////////////////////
`include "qsic_defines.svh"
`default_nettype none

module qsic_top
   import qsic_pkg::*;
(
   input  wire logic                                clk20,
   input  wire logic                                rst_n,
   input  wire bus_rx_t                             bus_rx,      // raw strobes
   input  wire logic [`QSIC_DAL_W-1:0]              dal_in,
   input  wire logic                                bs7,
   input  wire logic                                wtbt,
   input  wire logic [3:0]                          dev_ready,   // async
   output wire logic                                trply,
   output wire dal_ctl_t                            dal_ctl,
   output wire logic [`QSIC_DAL_W-1:0]              dal_out,
   input  wire logic                                xlate_req,
   input  wire xlate_cmd_t                          xlate_cmd,
   output wire logic                                xlate_ack,
   output wire xlate_rsp_t                          xlate_rsp,
   output wire logic [`QSIC_LT_ENTRIES-1:0]         loaded
);

   wire bus_rx_t                              rx_s;      // strobes in clk20
   wire logic [3:0]                           rdy_s;
   wire logic [3:0]                           reg_idx;
   wire logic                                 reg_wr;
   wire logic [`QSIC_DATA_W-1:0]              reg_wdata;
   wire logic [`QSIC_DATA_W-1:0]              reg_rdata;
   wire logic [$clog2(`QSIC_LT_ENTRIES)-1:0]  lt_sel;
   wire lt_entry_t                            lt_entry;

   sync_chain #(.T(bus_rx_t)) u_rx_sync (
      .clk20 (clk20),
      .rst_n (rst_n),
      .d     (bus_rx),
      .q     (rx_s)
   );

   sync_chain #(.T(logic [3:0])) u_rdy_sync (
      .clk20 (clk20),
      .rst_n (rst_n),
      .d     (dev_ready),
      .q     (rdy_s)
   );

   qbus_slave_ctl u_ctl (
      .clk20     (clk20),
      .rst_n     (rst_n),
      .rx        (rx_s),
      .dal_in    (dal_in),
      .bs7       (bs7),
      .wtbt      (wtbt),
      .trply     (trply),
      .dal_ctl   (dal_ctl),
      .dal_out   (dal_out),
      .reg_idx   (reg_idx),
      .reg_wr    (reg_wr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata)
   );

   load_table u_lt (
      .clk20     (clk20),
      .rst_n     (rst_n),
      .reg_idx   (reg_idx),
      .reg_wr    (reg_wr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .dev_ready (rdy_s),
      .lt_sel    (lt_sel),
      .lt_entry  (lt_entry),
      .loaded    (loaded)
   );

   block_xlate u_xlate (
      .clk20     (clk20),
      .rst_n     (rst_n),
      .xlate_req (xlate_req),
      .xlate_cmd (xlate_cmd),
      .xlate_ack (xlate_ack),
      .xlate_rsp (xlate_rsp),
      .lt_sel    (lt_sel),
      .lt_entry  (lt_entry),
      .loaded    (loaded)
   );

endmodule

`default_nettype wire

//--- tb_qsic.sv
////////////////////
// testbench for qsic_top, bus and translation tasks,
// directed tests, watchdog and verdict
////////////////////
`include "qsic_defines.svh"
`default_nettype none

module tb_qsic
   import qsic_pkg::*;
();

   localparam int CLK_PERIOD = 20;
   // reads, write+read, no-reply, xlate, loaded/ok
   localparam int OPS = 16 + 12 + 2 + 12 + 17;

   logic                                clk20;
   logic                                rst_n;
   bus_rx_t                             bus_rx;
   logic [`QSIC_DAL_W-1:0]              dal_in;
   logic                                bs7;
   logic                                wtbt;
   logic [3:0]                          dev_ready;
   logic                                trply;
   dal_ctl_t                            dal_ctl;
   logic [`QSIC_DAL_W-1:0]              dal_out;
   logic                                xlate_req;
   xlate_cmd_t                          xlate_cmd;
   logic                                xlate_ack;
   xlate_rsp_t                          xlate_rsp;
   logic [`QSIC_LT_ENTRIES-1:0]         loaded;

   // expected table contents
   logic                                exp_en  [`QSIC_LT_ENTRIES];
   logic [1:0]                          exp_dev [`QSIC_LT_ENTRIES];
   logic [`QSIC_DATA_W-1:0]             exp_off [`QSIC_LT_ENTRIES];
   integer                              seed = 32'h1024;

   qsic_top UUT (
      .clk20     (clk20),
      .rst_n     (rst_n),
      .bus_rx    (bus_rx),
      .dal_in    (dal_in),
      .bs7       (bs7),
      .wtbt      (wtbt),
      .dev_ready (dev_ready),
      .trply     (trply),
      .dal_ctl   (dal_ctl),
      .dal_out   (dal_out),
      .xlate_req (xlate_req),
      .xlate_cmd (xlate_cmd),
      .xlate_ack (xlate_ack),
      .xlate_rsp (xlate_rsp),
      .loaded    (loaded)
   );

   initial begin
      clk20 = 1'b0;
      forever #(CLK_PERIOD / 2) clk20 = ~clk20;
   end

   task automatic stop_fail(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else
         stop_fail($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
   endtask

   // inputs change 2 units after the edge, outputs already settled
   task automatic tick;
      @(posedge clk20);
      #2;
   endtask

   task automatic load_reset_model;
      exp_en  = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
      exp_dev = '{2'd0, 2'd2, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd2};
      exp_off = '{16'h10, 16'h00, 16'h12, 16'h13, 16'h14, 16'h15, 16'h16, 16'h01};
   endtask

   // byte address of window word idx
   function automatic logic [`QSIC_DAL_W-1:0] word_addr(input logic [3:0] idx);
      return `QSIC_DAL_W'(`QSIC_LT_BASE) + `QSIC_DAL_W'({idx, 1'b0});
   endfunction

   function automatic logic [15:0] exp_word(input logic [3:0] idx);
      if (idx[0]) begin
         return exp_off[idx[3:1]];
      end
      return {exp_en[idx[3:1]], 13'b0, exp_dev[idx[3:1]]};   // control word
   endfunction

   function automatic logic [7:0] exp_loaded;
      logic [7:0] v;
      for (int i = 0; i < 8; i++) begin
         v[i] = exp_en[i] & dev_ready[exp_dev[i]];   // enabled and device up
      end
      return v;
   endfunction

   task automatic addr_phase(input logic [21:0] addr, input logic b7, input logic wr);
      dal_in = addr;
      bs7    = b7;
      wtbt   = wr;
      tick;
      bus_rx.sync = 1'b1;
      repeat (5) tick;   // address held past capture
   endtask

   // wait for the reply to drop, then end the cycle
   task automatic end_cycle(input string name, input logic rd, input logic [15:0] exp);
      int n;
      n = 0;
      while (trply || dal_ctl != '0) begin
         if (rd && trply) check_eq(name, 64'(exp), 64'(dal_out));
         tick;
         n++;
      end
      assert (n <= 5) else stop_fail({name, ": reply stayed up too long after strobe"});
      bus_rx.sync = 1'b0;
      bs7         = 1'b0;
      wtbt        = 1'b0;
      repeat (4) tick;   // sync seen low before next cycle
   endtask

   task automatic bus_read(input string name, input logic [21:0] addr, input logic [15:0] exp);
      logic tx_seen;
      tx_seen = 1'b0;
      addr_phase(addr, 1'b1, 1'b0);
      bus_rx.din = 1'b1;
      while (!trply) begin
         tick;
         if (dal_ctl.tx) tx_seen = 1'b1;
         assert (tx_seen || !(dal_ctl.be || dal_ctl.st)) else
            stop_fail({name, ": be or st came before tx"});
      end
      check_eq({name, " dal_ctl"}, 64'(3'b111), 64'(dal_ctl));   // be, st, tx all up
      check_eq(name, 64'(exp), 64'(dal_out));
      bus_rx.din = 1'b0;
      end_cycle(name, 1'b1, exp);
   endtask

   task automatic bus_write(input logic [21:0] addr, input logic [15:0] data);
      addr_phase(addr, 1'b1, 1'b1);
      dal_in = 22'(data);
      tick;
      bus_rx.dout = 1'b1;
      while (!trply) tick;
      bus_rx.dout = 1'b0;
      end_cycle("bus_write", 1'b0, 16'h0);
   endtask

   // no trply and no transceiver enable for 20 cycles
   task automatic bus_noreply(input string name, input logic [21:0] addr, input logic b7);
      addr_phase(addr, b7, 1'b0);
      bus_rx.din = 1'b1;
      repeat (20) begin
         tick;
         assert (trply == 1'b0 && dal_ctl == '0) else
            stop_fail({name, ": slave replied to an address it does not own"});
      end
      bus_rx.din = 1'b0;
      tick;
      bus_rx.sync = 1'b0;
      bs7         = 1'b0;
      repeat (4) tick;
   endtask

   task automatic xlate(input string name, input logic [2:0] sel, input logic [12:0] blk);
      xlate_rsp_t exp;
      int         n;
      exp.lba = 32'(blk) + (32'(exp_off[sel]) << `QSIC_OFFSET_SHIFT);
      exp.dev = exp_dev[sel];
      exp.ok  = exp_en[sel] & dev_ready[exp_dev[sel]];
      xlate_cmd.sel = sel;
      xlate_cmd.blk = blk;
      xlate_req     = 1'b1;
      while (!xlate_ack) tick;
      check_eq(name, 64'(exp), 64'(xlate_rsp));
      tick;
      assert (xlate_ack) else stop_fail({name, ": ack dropped while req still high"});
      xlate_req = 1'b0;
      n = 0;
      while (xlate_ack) begin
         tick;
         n++;
      end
      assert (n == 1) else stop_fail({name, ": ack did not fall on the clock after req"});
      tick;
   endtask

   // watchdog, 40 cycles per operation plus reset
   initial begin
      #((8 + OPS * 40) * CLK_PERIOD);
      stop_fail("timeout, DUT stopped answering");
   end

   initial begin
      logic [31:0] r;
      logic [3:0]  widx [6];
      rst_n     = 1'b0;
      bus_rx    = '0;
      dal_in    = '0;
      bs7       = 1'b0;
      wtbt      = 1'b0;
      dev_ready = 4'hf;
      xlate_req = 1'b0;
      xlate_cmd = '0;
      widx      = '{4'd1, 4'd3, 4'd10, 4'd11, 4'd12, 4'd13};
      load_reset_model;
      repeat (8) tick;
      rst_n = 1'b1;
      check_eq("after_reset", 64'(0), 64'({trply, dal_ctl, xlate_ack}));

      // 1 reset contents
      for (int i = 0; i < 16; i++) begin
         bus_read($sformatf("reset_contents word %0d", i), word_addr(4'(i)), exp_word(4'(i)));
      end

      // 2 write then read back
      foreach (widx[k]) begin
         r = $random(seed);
         bus_write(word_addr(widx[k]), r[15:0]);
         if (widx[k][0]) begin
            exp_off[widx[k][3:1]] = r[15:0];
         end else begin
            exp_en[widx[k][3:1]]  = r[15];
            exp_dev[widx[k][3:1]] = r[1:0];
         end
      end
      foreach (widx[k]) begin
         bus_read($sformatf("write_read word %0d", widx[k]), word_addr(widx[k]),
                  exp_word(widx[k]));
      end

      // 3 outside the window, then bs7 low
      bus_noreply("no_reply_outside", 22'(13'o17700), 1'b1);
      bus_noreply("no_reply_bs7_low", word_addr(4'd3), 1'b0);

      // 4 arithmetic, every device up
      repeat (12) begin
         r = $random(seed);
         xlate("xlate_arith", r[2:0], r[15:3]);
      end

      // 5 device 0 down
      dev_ready = 4'b1110;
      repeat (4) tick;   // through the synchronizer
      check_eq("loaded_dev0_down", 64'(exp_loaded()), 64'(loaded));
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         xlate("ok_dev0_down", 3'(i), r[12:0]);
      end
      bus_write(word_addr(4'd14), 16'h0002);   // entry 7 off, still device 2
      exp_en[7] = 1'b0;
      check_eq("loaded_entry7_off", 64'(exp_loaded()), 64'(loaded));
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         xlate("ok_entry7_off", 3'(i), r[12:0]);
      end

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
qsic_pkg.sv
sync_chain.sv
qbus_slave_ctl.sv
load_table.sv
block_xlate.sv
qsic_top.sv
tb_qsic.sv

//--- Makefile
# verilator lint, simulation and cleanup

TB  := tb_qsic
RTL := qsic_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(RTL)
	verilator --lint-only --timing -f tb.f --top-module $(TB)

sim:
	verilator --binary --timing -f tb.f --top-module $(TB)
	@out="$$(./obj_dir/V$(TB))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir
